// ==== project.f ====
+incdir+tests
source/core_pkg.sv
source/uop_if.sv
source/imm_gen.sv
source/decode.sv
source/decode_stage.sv
source/dispatch_router.sv
source/decode_top.sv
tests/decode_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = decode_tb
FILELIST  = project.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== tests/decode_vectors.svh ====
// columns: instr, path (0 int, 1 ls, 2 illegal), {rs1, rs2, rd} present,
// {r, i, s, b, u, j}, imm, {sub, sra, lui, jalr, ls width, ld sign}
function automatic void load_vectors();
    // r type
    vecs.push_back({32'h002081B3, 2'd0, 3'b111, 6'b100000, 32'h00000000, 7'b0000000}); // add
    vecs.push_back({32'h407302B3, 2'd0, 3'b111, 6'b100000, 32'h00000000, 7'b1000000}); // sub
    vecs.push_back({32'h40A4D433, 2'd0, 3'b111, 6'b100000, 32'h00000000, 7'b0100000}); // sra
    vecs.push_back({32'h00A4D433, 2'd0, 3'b111, 6'b100000, 32'h00000000, 7'b0000000}); // srl
    // i type alu, negative and max positive immediates
    vecs.push_back({32'hFFF10093, 2'd0, 3'b101, 6'b010000, 32'hFFFFFFFF, 7'b0000000}); // addi
    vecs.push_back({32'h7FF00213, 2'd0, 3'b101, 6'b010000, 32'h000007FF, 7'b0000000}); // addi
    vecs.push_back({32'h40365593, 2'd0, 3'b101, 6'b010000, 32'h00000403, 7'b0100000}); // srai
    vecs.push_back({32'h00365593, 2'd0, 3'b101, 6'b010000, 32'h00000003, 7'b0000000}); // srli
    // loads, width and zero-extend flag from funct3
    vecs.push_back({32'hFFC70683, 2'd1, 3'b101, 6'b010000, 32'hFFFFFFFC, 7'b0000000}); // lb
    vecs.push_back({32'h00474683, 2'd1, 3'b101, 6'b010000, 32'h00000004, 7'b0000001}); // lbu
    vecs.push_back({32'h00209783, 2'd1, 3'b101, 6'b010000, 32'h00000002, 7'b0000010}); // lh
    vecs.push_back({32'h0020D783, 2'd1, 3'b101, 6'b010000, 32'h00000002, 7'b0000011}); // lhu
    vecs.push_back({32'h10012803, 2'd1, 3'b101, 6'b010000, 32'h00000100, 7'b0000100}); // lw
    // stores
    vecs.push_back({32'hFF190FA3, 2'd1, 3'b110, 6'b001000, 32'hFFFFFFFF, 7'b0000000}); // sb
    vecs.push_back({32'h013A1423, 2'd1, 3'b110, 6'b001000, 32'h00000008, 7'b0000010}); // sh
    vecs.push_back({32'h035B2223, 2'd1, 3'b110, 6'b001000, 32'h00000024, 7'b0000100}); // sw
    // branches
    vecs.push_back({32'hFE208CE3, 2'd0, 3'b110, 6'b000100, 32'hFFFFFFF8, 7'b0000000}); // beq
    vecs.push_back({32'h00419863, 2'd0, 3'b110, 6'b000100, 32'h00000010, 7'b0000000}); // bne
    // upper immediates and jumps
    vecs.push_back({32'h123452B7, 2'd0, 3'b001, 6'b000010, 32'h12345000, 7'b0010000}); // lui
    vecs.push_back({32'hFFFFF317, 2'd0, 3'b001, 6'b000010, 32'hFFFFF000, 7'b0000000}); // auipc
    vecs.push_back({32'h001000EF, 2'd0, 3'b001, 6'b000001, 32'h00000800, 7'b0000000}); // jal
    vecs.push_back({32'hFFDFF06F, 2'd0, 3'b001, 6'b000001, 32'hFFFFFFFC, 7'b0000000}); // jal
    vecs.push_back({32'h00C280E7, 2'd0, 3'b101, 6'b010000, 32'h0000000C, 7'b0001000}); // jalr
    // system opcode and an all-zero word get no tag
    vecs.push_back({32'h00000073, 2'd2, 3'b000, 6'b000000, 32'h00000000, 7'b0000000}); // ecall
    vecs.push_back({32'h00000000, 2'd2, 3'b000, 6'b000000, 32'h00000000, 7'b0000000});
endfunction

// ==== tests/decode_tb.sv ====
`timescale 1ns/1ps

module decode_tb;

    typedef struct packed {
        core_pkg::instr_t instr;
        logic [1:0]       path;   // 0 int, 1 load/store, 2 illegal
        logic [2:0]       regv;   // rs1, rs2, rd present
        logic [5:0]       fmt;    // r, i, s, b, u, j
        core_pkg::imm_t   imm;
        logic [6:0]       qual;   // sub, sra, lui, jalr, ls width, ld sign
    } vec_t;

    logic clk;
    logic rst;
    logic instr_valid;
    core_pkg::instr_t instr;
    logic int_valid, ls_valid, illegal_valid;
    core_pkg::rob_tag_t int_tag, ls_tag;
    core_pkg::arf_id_t rs1, rs2, rd;
    logic rs1_valid, rs2_valid, rd_valid;
    core_pkg::funct3_t funct3;
    core_pkg::imm_t imm;
    logic is_r_type, is_i_type, is_s_type, is_b_type, is_u_type, is_j_type;
    logic is_sub, is_sra_srai, is_lui, is_jalr;
    core_pkg::req_width_t ls_width;
    logic ld_sign;

    vec_t vecs[$];
    vec_t exp_q[$];     // expected items in issue order
    int   issue_q[$];   // cycle of each strobe
    int   cycle = 0;

    `include "decode_vectors.svh"

    decode_top u_dut (.*);

    always #50 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    task automatic compare(input string field, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, field, got, exp);
            $display(">>> FAIL");
            $fatal(1, "output mismatch");
        end
    endtask

    function automatic logic output_seen();
        return (int_valid === 1'b1) || (ls_valid === 1'b1) || (illegal_valid === 1'b1);
    endfunction

    initial begin
        integer seed;
        int     gap;
        seed        = 32'h34be;
        clk         = 1'b0;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (2) begin   // second pass carries the tag past 31
            foreach (vecs[i]) begin
                @(posedge clk);
                #1;
                instr_valid = 1'b1;
                instr       = vecs[i].instr;
                exp_q.push_back(vecs[i]);
                issue_q.push_back(cycle);
                gap = {$random(seed)} % 3;   // zero gives back-to-back strobes
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                    instr_valid = 1'b0;
                end
            end
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
    end

    initial begin
        vec_t v;
        int   issued;
        int   wait_cnt;
        int   tag;
        int   extra;
        tag = 0;
        extra = 0;
        load_vectors();
        for (int n = 0; n < 2 * vecs.size(); n++) begin
            wait_cnt = 0;
            do begin
                @(negedge clk);   // outputs settle between edges
                wait_cnt++;
            end while (!output_seen() && wait_cnt < 20);
            if (!output_seen()) begin
                $display("no output valid within 20 cycles for item %0d", n);
                $display(">>> FAIL");
                $fatal(1, "timeout");
            end
            if (exp_q.size() == 0) begin
                $display("output valid at %0t ns with no instruction in flight", $time);
                $display(">>> FAIL");
                $fatal(1, "unexpected output");
            end
            v = exp_q.pop_front();
            issued = issue_q.pop_front();
            compare("latency", 32'(cycle - issued), 32'd2);
            compare("int_valid", 32'(int_valid), 32'(v.path == 2'd0));
            compare("ls_valid", 32'(ls_valid), 32'(v.path == 2'd1));
            compare("illegal_valid", 32'(illegal_valid), 32'(v.path == 2'd2));
            if (v.path != 2'd2) begin
                compare("tag", 32'((v.path == 2'd1) ? ls_tag : int_tag), 32'(tag));
                tag = (tag + 1) % (1 << core_pkg::ROB_TAG_WIDTH);
                compare("type flags", 32'({is_r_type, is_i_type, is_s_type, is_b_type,
                        is_u_type, is_j_type}), 32'(v.fmt));
                compare("reg valids", 32'({rs1_valid, rs2_valid, rd_valid}), 32'(v.regv));
                if (v.regv[2])
                    compare("rs1", 32'(rs1), 32'(v.instr[19:15]));
                if (v.regv[1])
                    compare("rs2", 32'(rs2), 32'(v.instr[24:20]));
                if (v.regv[0])
                    compare("rd", 32'(rd), 32'(v.instr[11:7]));
                compare("funct3", 32'(funct3), 32'(v.instr[14:12]));
                compare("imm", imm, v.imm);
                compare("qualifiers", 32'({is_sub, is_sra_srai, is_lui, is_jalr}),
                        32'(v.qual[6:3]));
                if (v.path == 2'd1)
                    compare("ls width/sign", 32'({ls_width, ld_sign}), 32'(v.qual[2:0]));
            end
        end
        repeat (5) begin   // nothing may come out after the last item
            @(negedge clk);
            if (output_seen())
                extra++;
        end
        if (extra != 0) begin
            $display("%0d output valids seen after the last instruction", extra);
            $display(">>> FAIL");
            $fatal(1, "stray outputs");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// ==== source/decode_top.sv ====
`timescale 1ns/1ps

module decode_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 instr_valid,
    input  core_pkg::instr_t     instr,
    // integer path
    output logic                 int_valid,
    output core_pkg::rob_tag_t   int_tag,
    output core_pkg::arf_id_t    rs1,
    output core_pkg::arf_id_t    rs2,
    output core_pkg::arf_id_t    rd,
    output logic                 rs1_valid,
    output logic                 rs2_valid,
    output logic                 rd_valid,
    output core_pkg::funct3_t    funct3,
    output core_pkg::imm_t       imm,
    output logic                 is_r_type,
    output logic                 is_i_type,
    output logic                 is_s_type,
    output logic                 is_b_type,
    output logic                 is_u_type,
    output logic                 is_j_type,
    output logic                 is_sub,
    output logic                 is_sra_srai,
    output logic                 is_lui,
    output logic                 is_jalr,
    // load/store path, operands and imm shared with the integer path
    output logic                 ls_valid,
    output core_pkg::rob_tag_t   ls_tag,
    output core_pkg::req_width_t ls_width,
    output logic                 ld_sign,
    output logic                 illegal_valid
);

    uop_if u_uop ();

    decode_stage u_decode_stage (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .uop         (u_uop.producer)
    );

    dispatch_router u_dispatch_router (
        .clk           (clk),
        .rst           (rst),
        .uop           (u_uop.consumer),
        .int_valid     (int_valid),
        .int_tag       (int_tag),
        .ls_valid      (ls_valid),
        .ls_tag        (ls_tag),
        .illegal_valid (illegal_valid),
        .rs1           (rs1),
        .rs2           (rs2),
        .rd            (rd),
        .rs1_valid     (rs1_valid),
        .rs2_valid     (rs2_valid),
        .rd_valid      (rd_valid),
        .funct3        (funct3),
        .imm           (imm),
        .is_r_type     (is_r_type),
        .is_i_type     (is_i_type),
        .is_s_type     (is_s_type),
        .is_b_type     (is_b_type),
        .is_u_type     (is_u_type),
        .is_j_type     (is_j_type),
        .is_sub        (is_sub),
        .is_sra_srai   (is_sra_srai),
        .is_lui        (is_lui),
        .is_jalr       (is_jalr),
        .ls_width      (ls_width),
        .ld_sign       (ld_sign)
    );

endmodule

// ==== source/dispatch_router.sv ====
`timescale 1ns/1ps

module dispatch_router (
    input  logic                 clk,
    input  logic                 rst,
    uop_if.consumer              uop,
    output logic                 int_valid,
    output core_pkg::rob_tag_t   int_tag,
    output logic                 ls_valid,
    output core_pkg::rob_tag_t   ls_tag,
    output logic                 illegal_valid,
    output core_pkg::arf_id_t    rs1,
    output core_pkg::arf_id_t    rs2,
    output core_pkg::arf_id_t    rd,
    output logic                 rs1_valid,
    output logic                 rs2_valid,
    output logic                 rd_valid,
    output core_pkg::funct3_t    funct3,
    output core_pkg::imm_t       imm,
    output logic                 is_r_type,
    output logic                 is_i_type,
    output logic                 is_s_type,
    output logic                 is_b_type,
    output logic                 is_u_type,
    output logic                 is_j_type,
    output logic                 is_sub,
    output logic                 is_sra_srai,
    output logic                 is_lui,
    output logic                 is_jalr,
    output core_pkg::req_width_t ls_width,
    output logic                 ld_sign
);

    core_pkg::rob_tag_t tag_cnt;   // next tag to hand out
    core_pkg::rob_tag_t out_tag;
    logic               legal;

    assign legal = uop.valid & ~uop.illegal;

    always_ff @(posedge clk) begin
        if (rst) begin
            int_valid     <= 1'b0;
            ls_valid      <= 1'b0;
            illegal_valid <= 1'b0;
            tag_cnt       <= '0;
        end else begin
            int_valid     <= legal & ~uop.is_ls_instr;
            ls_valid      <= legal & uop.is_ls_instr;
            illegal_valid <= uop.valid & uop.illegal;
            if (legal) begin
                tag_cnt <= tag_cnt + core_pkg::rob_tag_t'(1);   // wraps after 31
            end
        end
    end

    always_ff @(posedge clk) begin
        if (legal) begin
            out_tag <= tag_cnt;
        end
        if (uop.valid) begin
            rs1         <= uop.rs1;
            rs2         <= uop.rs2;
            rd          <= uop.rd;
            rs1_valid   <= uop.rs1_valid;
            rs2_valid   <= uop.rs2_valid;
            rd_valid    <= uop.rd_valid;
            funct3      <= uop.funct3;
            imm         <= uop.imm;
            is_r_type   <= uop.is_r_type;
            is_i_type   <= uop.is_i_type;
            is_s_type   <= uop.is_s_type;
            is_b_type   <= uop.is_b_type;
            is_u_type   <= uop.is_u_type;
            is_j_type   <= uop.is_j_type;
            is_sub      <= uop.is_sub;
            is_sra_srai <= uop.is_sra_srai;
            is_lui      <= uop.is_lui;
            is_jalr     <= uop.is_jalr;
            ls_width    <= uop.ls_width;
            ld_sign     <= uop.ld_sign;
        end
    end

    // only one path is valid per cycle, so both share the tag register
    assign int_tag = out_tag;
    assign ls_tag  = out_tag;

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             instr_valid,
    input  core_pkg::instr_t instr,
    uop_if.producer          uop
);

    core_pkg::arf_id_t    d_rs1;
    core_pkg::arf_id_t    d_rs2;
    core_pkg::arf_id_t    d_rd;
    logic                 d_rs1_valid;
    logic                 d_rs2_valid;
    logic                 d_rd_valid;
    core_pkg::funct3_t    d_funct3;
    core_pkg::imm_t       d_imm;
    logic [5:0]           d_type;      // r, i, s, b, u, j
    logic                 d_is_sub;
    logic                 d_is_sra_srai;
    logic                 d_is_lui;
    logic                 d_is_jalr;
    logic                 d_is_ls_instr;
    core_pkg::req_width_t d_ls_width;
    logic                 d_ld_sign;
    logic                 d_illegal;

    decode u_decode (
        .instr       (instr),
        .rs1         (d_rs1),
        .rs2         (d_rs2),
        .rd          (d_rd),
        .rs1_valid   (d_rs1_valid),
        .rs2_valid   (d_rs2_valid),
        .rd_valid    (d_rd_valid),
        .funct3      (d_funct3),
        .imm         (d_imm),
        .is_r_type   (d_type[5]),
        .is_i_type   (d_type[4]),
        .is_s_type   (d_type[3]),
        .is_b_type   (d_type[2]),
        .is_u_type   (d_type[1]),
        .is_j_type   (d_type[0]),
        .is_sub      (d_is_sub),
        .is_sra_srai (d_is_sra_srai),
        .is_lui      (d_is_lui),
        .is_jalr     (d_is_jalr),
        .is_ls_instr (d_is_ls_instr),
        .ls_width    (d_ls_width),
        .ld_sign     (d_ld_sign),
        .illegal     (d_illegal)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            uop.valid <= 1'b0;
        end else begin
            uop.valid <= instr_valid;
        end
    end

    // payload only moves on a strobe and holds otherwise
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            uop.rs1         <= d_rs1;
            uop.rs2         <= d_rs2;
            uop.rd          <= d_rd;
            uop.rs1_valid   <= d_rs1_valid;
            uop.rs2_valid   <= d_rs2_valid;
            uop.rd_valid    <= d_rd_valid;
            uop.funct3      <= d_funct3;
            uop.imm         <= d_imm;
            uop.is_r_type   <= d_type[5];
            uop.is_i_type   <= d_type[4];
            uop.is_s_type   <= d_type[3];
            uop.is_b_type   <= d_type[2];
            uop.is_u_type   <= d_type[1];
            uop.is_j_type   <= d_type[0];
            uop.is_sub      <= d_is_sub;
            uop.is_sra_srai <= d_is_sra_srai;
            uop.is_lui      <= d_is_lui;
            uop.is_jalr     <= d_is_jalr;
            uop.is_ls_instr <= d_is_ls_instr;
            uop.ls_width    <= d_ls_width;
            uop.ld_sign     <= d_ld_sign;
            uop.illegal     <= d_illegal;
        end
    end

endmodule

// ==== source/decode.sv ====
`timescale 1ns/1ps

module decode (
    input  core_pkg::instr_t     instr,
    output core_pkg::arf_id_t    rs1,
    output core_pkg::arf_id_t    rs2,
    output core_pkg::arf_id_t    rd,
    output logic                 rs1_valid,   // valid here means the operand exists
    output logic                 rs2_valid,
    output logic                 rd_valid,
    output core_pkg::funct3_t    funct3,      // alu op or branch condition
    output core_pkg::imm_t       imm,
    output logic                 is_r_type,
    output logic                 is_i_type,
    output logic                 is_s_type,
    output logic                 is_b_type,
    output logic                 is_u_type,   // lui and auipc
    output logic                 is_j_type,   // jal only
    output logic                 is_sub,      // r type: 0 = add, 1 = sub
    output logic                 is_sra_srai, // right shift: 1 = arithmetic
    output logic                 is_lui,      // u type: 0 = auipc
    output logic                 is_jalr,
    output logic                 is_ls_instr,
    output core_pkg::req_width_t ls_width,
    output logic                 ld_sign,
    output logic                 illegal
);

    core_pkg::opcode_t opcode;
    logic              funct7_b5;

    logic is_op_opcode;
    logic is_op_imm_opcode;
    logic is_ld_opcode;
    logic is_st_opcode;
    logic is_jalr_opcode;
    logic is_lui_opcode;
    logic is_auipc_opcode;

    assign opcode    = instr[6:0];
    assign funct7_b5 = instr[30];

    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // opcode match against the base set
    assign is_op_opcode     = (opcode == core_pkg::OP_OPCODE);
    assign is_op_imm_opcode = (opcode == core_pkg::OP_IMM_OPCODE);
    assign is_ld_opcode     = (opcode == core_pkg::LD_OPCODE);
    assign is_st_opcode     = (opcode == core_pkg::ST_OPCODE);
    assign is_jalr_opcode   = (opcode == core_pkg::JALR_OPCODE);
    assign is_lui_opcode    = (opcode == core_pkg::LUI_OPCODE);
    assign is_auipc_opcode  = (opcode == core_pkg::AUIPC_OPCODE);

    assign is_r_type = is_op_opcode;
    assign is_i_type = is_op_imm_opcode | is_ld_opcode | is_jalr_opcode;
    assign is_s_type = is_st_opcode;
    assign is_b_type = (opcode == core_pkg::BR_OPCODE);
    assign is_u_type = is_lui_opcode | is_auipc_opcode;
    assign is_j_type = (opcode == core_pkg::JAL_OPCODE);

    // fence, system, csr and anything unknown land here
    assign illegal = ~(is_r_type | is_i_type | is_s_type | is_b_type | is_u_type | is_j_type);

    // operand presence per format
    assign rs1_valid = is_r_type | is_i_type | is_s_type | is_b_type;
    assign rs2_valid = is_r_type | is_s_type | is_b_type;
    assign rd_valid  = is_r_type | is_i_type | is_u_type | is_j_type;

    imm_gen u_imm_gen (
        .instr     (instr),
        .is_i_type (is_i_type),
        .is_s_type (is_s_type),
        .is_b_type (is_b_type),
        .is_u_type (is_u_type),
        .is_j_type (is_j_type),
        .imm       (imm)
    );

    assign is_sub = is_op_opcode & (funct3 == core_pkg::SUB_FUNCT3) & funct7_b5;

    // srai keeps funct7[5] in the same spot as sra, so one check covers both
    assign is_sra_srai = (is_op_opcode | is_op_imm_opcode)
                       & (funct3 == core_pkg::SRA_FUNCT3) & funct7_b5;

    assign is_lui      = is_lui_opcode;
    assign is_jalr     = is_jalr_opcode;
    assign is_ls_instr = is_ld_opcode | is_st_opcode;

    assign ls_width = core_pkg::req_width_t'(funct3[1:0]);
    assign ld_sign  = funct3[2];   // set for lbu/lhu, zero-extending loads

endmodule

// ==== source/imm_gen.sv ====
`timescale 1ns/1ps

module imm_gen (
    input  core_pkg::instr_t instr,
    input  logic             is_i_type,
    input  logic             is_s_type,
    input  logic             is_b_type,
    input  logic             is_u_type,
    input  logic             is_j_type,
    output core_pkg::imm_t   imm
);

    core_pkg::imm_t i_imm;
    core_pkg::imm_t s_imm;
    core_pkg::imm_t b_imm;
    core_pkg::imm_t u_imm;
    core_pkg::imm_t j_imm;

    // sign bit is instr[31] in every format
    assign i_imm = {{20{instr[31]}}, instr[31:20]};
    assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign b_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'b0};   // upper 20 bits, low bits zero
    assign j_imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    // one-hot and-or select, nothing set gives zero (r type, illegal)
    assign imm = ({32{is_i_type}} & i_imm)
               | ({32{is_s_type}} & s_imm)
               | ({32{is_b_type}} & b_imm)
               | ({32{is_u_type}} & u_imm)
               | ({32{is_j_type}} & j_imm);

endmodule

// ==== source/uop_if.sv ====
`timescale 1ns/1ps

interface uop_if;

    logic                 valid;       // one-cycle strobe
    core_pkg::arf_id_t    rs1;
    core_pkg::arf_id_t    rs2;
    core_pkg::arf_id_t    rd;
    logic                 rs1_valid;   // operand exists
    logic                 rs2_valid;
    logic                 rd_valid;
    core_pkg::funct3_t    funct3;
    core_pkg::imm_t       imm;
    logic                 is_r_type;
    logic                 is_i_type;
    logic                 is_s_type;
    logic                 is_b_type;
    logic                 is_u_type;
    logic                 is_j_type;
    logic                 is_sub;
    logic                 is_sra_srai;
    logic                 is_lui;
    logic                 is_jalr;
    logic                 is_ls_instr;
    core_pkg::req_width_t ls_width;
    logic                 ld_sign;
    logic                 illegal;     // opcode outside the supported set

    modport producer (
        output valid, rs1, rs2, rd, rs1_valid, rs2_valid, rd_valid, funct3, imm,
               is_r_type, is_i_type, is_s_type, is_b_type, is_u_type, is_j_type,
               is_sub, is_sra_srai, is_lui, is_jalr, is_ls_instr, ls_width, ld_sign,
               illegal
    );

    modport consumer (
        input valid, rs1, rs2, rd, rs1_valid, rs2_valid, rd_valid, funct3, imm,
              is_r_type, is_i_type, is_s_type, is_b_type, is_u_type, is_j_type,
              is_sub, is_sra_srai, is_lui, is_jalr, is_ls_instr, ls_width, ld_sign,
              illegal
    );

endinterface

// ==== source/core_pkg.sv ====
package core_pkg;

    // raw instruction and field types
    typedef logic [31:0] instr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [4:0]  arf_id_t;   // architectural register index
    typedef logic [2:0]  funct3_t;
    typedef logic [31:0] imm_t;      // always sign-extended to xlen

    localparam int ROB_TAG_WIDTH = 5;
    typedef logic [ROB_TAG_WIDTH-1:0] rob_tag_t;

    // memory access size, taken straight from funct3[1:0]
    typedef enum logic [1:0] {
        BYTE     = 2'b00,
        HALFWORD = 2'b01,
        WORD     = 2'b10,
        ERROR    = 2'b11
    } req_width_t;

    // major opcodes, rv32i base set
    localparam opcode_t OP_OPCODE     = 7'b0110011;
    localparam opcode_t OP_IMM_OPCODE = 7'b0010011;
    localparam opcode_t LD_OPCODE     = 7'b0000011;
    localparam opcode_t ST_OPCODE     = 7'b0100011;
    localparam opcode_t BR_OPCODE     = 7'b1100011;
    localparam opcode_t LUI_OPCODE    = 7'b0110111;
    localparam opcode_t AUIPC_OPCODE  = 7'b0010111;
    localparam opcode_t JAL_OPCODE    = 7'b1101111;
    localparam opcode_t JALR_OPCODE   = 7'b1100111;

    // add/sub share funct3, split by funct7[5]
    localparam funct3_t SUB_FUNCT3 = 3'b000;
    // srl/sra and srli/srai, split by funct7[5]
    localparam funct3_t SRA_FUNCT3 = 3'b101;

endpackage
